//--- hdl/spike_axil_regs.sv
`timescale 1ns/1ns

module spike_axil_regs (
    input  logic                                              reset,
    input  logic                                              slow_clk,
    // write address and data
    input  spike_pkg::axi_addr_t                              awaddr,
    input  logic                                              awvalid,
    output logic                                              awready,
    input  spike_pkg::axi_data_t                              wdata,
    input  logic [spike_pkg::AXI_DATA_W/8-1:0]                wstrb,
    input  logic                                              wvalid,
    output logic                                              wready,
    // write response
    output logic [1:0]                                        bresp,
    output logic                                              bvalid,
    input  logic                                              bready,
    // read address
    input  spike_pkg::axi_addr_t                              araddr,
    input  logic                                              arvalid,
    output logic                                              arready,
    // read data
    output spike_pkg::axi_data_t                              rdata,
    output logic [1:0]                                        rresp,
    output logic                                              rvalid,
    input  logic                                              rready,
    // status from the datapath
    input  logic [spike_pkg::NUM_CHANNELS*spike_pkg::COUNT_W-1:0] count_bus,
    input  spike_pkg::win_idx_t                               win_idx,
    // control to the datapath
    output logic                                              enable,
    output spike_pkg::win_len_t                               win_len
);

    // shared by the read and the write fsm
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ACCEPT,
        ST_RESP
    } axi_state_t;

    axi_state_t           wr_state;
    axi_state_t           rd_state;
    // write data merged with the old register under wstrb
    spike_pkg::axi_data_t len_merged;
    spike_pkg::win_len_t  len_floored;
    // read mux result
    spike_pkg::axi_data_t rd_value;
    logic                 rd_ok;
    // offset into the count block
    spike_pkg::axi_addr_t ch_off;

    // ready and valid straight from state
    assign awready = (wr_state == ST_ACCEPT);
    assign wready  = (wr_state == ST_ACCEPT);
    assign bvalid  = (wr_state == ST_RESP);
    assign arready = (rd_state == ST_ACCEPT);
    assign rvalid  = (rd_state == ST_RESP);

    // byte-lane merge for the window length
    always_comb begin
        len_merged = spike_pkg::axi_data_t'(win_len);
        for (int b = 0; b < spike_pkg::AXI_DATA_W / 8; b++) begin
            if (wstrb[b]) begin
                len_merged[b*8 +: 8] = wdata[b*8 +: 8];
            end
        end
        // upper byte is dropped, register is 24 bits
        len_floored = len_merged[spike_pkg::WIN_W-1:0];
        if (len_floored < spike_pkg::MIN_WIN_LEN) begin
            len_floored = spike_pkg::MIN_WIN_LEN;
        end
    end

    // write fsm
    // waits for aw and w together, acks both in one cycle
    always_ff @(posedge reset or posedge slow_clk) begin
        if (slow_clk) begin
            wr_state <= ST_IDLE;
            enable   <= 1'b0;
            win_len  <= spike_pkg::DEFAULT_WIN_LEN;
        end else begin
            case (wr_state)
                ST_IDLE: begin
                    if (awvalid && wvalid) begin
                        wr_state <= ST_ACCEPT;
                    end
                end
                ST_ACCEPT: begin
                    // handshake completes this cycle
                    if (awaddr == spike_pkg::REG_CTRL && wstrb[0]) begin
                        enable <= wdata[0];
                    end else if (awaddr == spike_pkg::REG_WIN_LEN) begin
                        win_len <= len_floored;
                    end
                    wr_state <= ST_RESP;
                end
                ST_RESP: begin
                    if (bready) begin
                        wr_state <= ST_IDLE;
                    end
                end
                default: wr_state <= ST_IDLE;
            endcase
        end
    end

    // write response code, only the two rw registers are writable
    always_ff @(posedge reset) begin
        if (wr_state == ST_ACCEPT) begin
            if (awaddr == spike_pkg::REG_CTRL || awaddr == spike_pkg::REG_WIN_LEN) begin
                bresp <= spike_pkg::RESP_OKAY;
            end else begin
                bresp <= spike_pkg::RESP_SLVERR;
            end
        end
    end

    // read address decode
    always_comb begin
        rd_value = '0;
        rd_ok    = 1'b1;
        ch_off   = araddr - spike_pkg::REG_COUNT_BASE;
        if (araddr == spike_pkg::REG_CTRL) begin
            rd_value = spike_pkg::axi_data_t'(enable);
        end else if (araddr == spike_pkg::REG_WIN_LEN) begin
            rd_value = spike_pkg::axi_data_t'(win_len);
        end else if (araddr == spike_pkg::REG_WIN_IDX) begin
            rd_value = spike_pkg::axi_data_t'(win_idx);
        end else if (araddr >= spike_pkg::REG_COUNT_BASE &&
                     araddr < spike_pkg::REG_COUNT_BASE + 4 * spike_pkg::NUM_CHANNELS &&
                     araddr[1:0] == 2'b00) begin
            // word index picks the channel
            rd_value = spike_pkg::axi_data_t'(
                count_bus[ch_off[spike_pkg::AXI_ADDR_W-1:2] * spike_pkg::COUNT_W +:
                          spike_pkg::COUNT_W]);
        end else begin
            // unmapped reads back zero
            rd_ok = 1'b0;
        end
    end

    // read fsm
    always_ff @(posedge reset or posedge slow_clk) begin
        if (slow_clk) begin
            rd_state <= ST_IDLE;
        end else begin
            case (rd_state)
                ST_IDLE: begin
                    if (arvalid) begin
                        rd_state <= ST_ACCEPT;
                    end
                end
                ST_ACCEPT: rd_state <= ST_RESP;
                ST_RESP: begin
                    // hold until the master takes it
                    if (rready) begin
                        rd_state <= ST_IDLE;
                    end
                end
                default: rd_state <= ST_IDLE;
            endcase
        end
    end

    // capture on the ar handshake, stable while rvalid is up
    always_ff @(posedge reset) begin
        if (rd_state == ST_ACCEPT) begin
            rdata <= rd_value;
            rresp <= rd_ok ? spike_pkg::RESP_OKAY : spike_pkg::RESP_SLVERR;
        end
    end

endmodule

//--- hdl/spike_counter.sv
`timescale 1ns/1ns

module spike_counter (
    input  logic              reset,
    input  logic              slow_clk,
    input  logic              spike_edge,
    input  logic              window_end,
    output spike_pkg::count_t int_cnt_out
);

    // running count of the open window
    spike_pkg::count_t cnt;
    // count including this cycle's edge
    spike_pkg::count_t cnt_next;
    logic              at_max;

    // all ones means saturated
    assign at_max = (cnt == {spike_pkg::COUNT_W{1'b1}});

    // add the edge unless already pinned at max
    always_comb begin
        cnt_next = cnt;
        if (spike_edge && !at_max) begin
            cnt_next = cnt + 1'b1;
        end
    end

    // running counter
    always_ff @(posedge reset or posedge slow_clk) begin
        if (slow_clk) begin
            cnt <= '0;
        end else if (window_end) begin
            // restart for the next window
            cnt <= '0;
        end else begin
            cnt <= cnt_next;
        end
    end

    // latched result of the last full window
    always_ff @(posedge reset or posedge slow_clk) begin
        if (slow_clk) begin
            int_cnt_out <= '0;
        end else if (window_end) begin
            // edge in the boundary cycle belongs to the ending window,
            // so nothing is dropped between windows
            int_cnt_out <= cnt_next;
        end
    end

    // int_cnt_out updates one clock after window_end
    // it holds until the next boundary, even with a zero count

endmodule

//--- hdl/spike_monitor_top.sv
`timescale 1ns/1ns

module spike_monitor_top (
    input  logic                               reset,
    input  logic                               slow_clk,
    // asynchronous spike inputs
    input  logic [spike_pkg::NUM_CHANNELS-1:0] spike,
    // axi4-lite slave
    input  spike_pkg::axi_addr_t               awaddr,
    input  logic                               awvalid,
    output logic                               awready,
    input  spike_pkg::axi_data_t               wdata,
    input  logic [spike_pkg::AXI_DATA_W/8-1:0] wstrb,
    input  logic                               wvalid,
    output logic                               wready,
    output logic [1:0]                         bresp,
    output logic                               bvalid,
    input  logic                               bready,
    input  spike_pkg::axi_addr_t               araddr,
    input  logic                               arvalid,
    output logic                               arready,
    output spike_pkg::axi_data_t               rdata,
    output logic [1:0]                         rresp,
    output logic                               rvalid,
    input  logic                               rready
);

    // synchronized edges, one per channel
    logic [spike_pkg::NUM_CHANNELS-1:0] spike_edge;
    // edges that reach the counters
    logic [spike_pkg::NUM_CHANNELS-1:0] counted_edge;
    logic                               window_end;
    spike_pkg::win_idx_t                win_idx;
    logic                               enable;
    spike_pkg::win_len_t                win_len;
    // latched counts, channel 0 in the low bits
    logic [spike_pkg::NUM_CHANNELS*spike_pkg::COUNT_W-1:0] count_bus;

    // front end for all channels
    spike_sync u_sync (
        .reset      (reset),
        .slow_clk   (slow_clk),
        .spike      (spike),
        .spike_edge (spike_edge)
    );

    // no counting while disabled
    assign counted_edge = spike_edge & {spike_pkg::NUM_CHANNELS{enable}};

    // window generator
    window_timer u_timer (
        .reset      (reset),
        .slow_clk   (slow_clk),
        .enable     (enable),
        .win_len    (win_len),
        .window_end (window_end),
        .win_idx    (win_idx)
    );

    // one counter per channel
    for (genvar ch = 0; ch < spike_pkg::NUM_CHANNELS; ch++) begin : g_chan
        spike_counter u_counter (
            .reset       (reset),
            .slow_clk    (slow_clk),
            .spike_edge  (counted_edge[ch]),
            .window_end  (window_end),
            .int_cnt_out (count_bus[ch*spike_pkg::COUNT_W +: spike_pkg::COUNT_W])
        );
    end

    // software access
    spike_axil_regs u_regs (
        .reset     (reset),
        .slow_clk  (slow_clk),
        .awaddr    (awaddr),
        .awvalid   (awvalid),
        .awready   (awready),
        .wdata     (wdata),
        .wstrb     (wstrb),
        .wvalid    (wvalid),
        .wready    (wready),
        .bresp     (bresp),
        .bvalid    (bvalid),
        .bready    (bready),
        .araddr    (araddr),
        .arvalid   (arvalid),
        .arready   (arready),
        .rdata     (rdata),
        .rresp     (rresp),
        .rvalid    (rvalid),
        .rready    (rready),
        .count_bus (count_bus),
        .win_idx   (win_idx),
        .enable    (enable),
        .win_len   (win_len)
    );

endmodule

//--- hdl/spike_pkg.sv
package spike_pkg;

    // channel count and datapath widths
    localparam int NUM_CHANNELS = 4;
    localparam int COUNT_W      = 16;
    localparam int WIN_W        = 24;

    // axi4-lite bus widths
    localparam int AXI_ADDR_W   = 8;
    localparam int AXI_DATA_W   = 32;

    // spike count of one window
    typedef logic [COUNT_W-1:0]    count_t;
    // window length in clock cycles
    typedef logic [WIN_W-1:0]      win_len_t;
    // number of completed windows
    typedef logic [WIN_W-1:0]      win_idx_t;
    typedef logic [AXI_ADDR_W-1:0] axi_addr_t;
    typedef logic [AXI_DATA_W-1:0] axi_data_t;

    // register map, byte offsets
    localparam axi_addr_t REG_CTRL       = 8'h00;
    localparam axi_addr_t REG_WIN_LEN    = 8'h04;
    localparam axi_addr_t REG_WIN_IDX    = 8'h08;
    // channel n sits at base + 4*n
    localparam axi_addr_t REG_COUNT_BASE = 8'h10;

    // window length after reset
    localparam win_len_t DEFAULT_WIN_LEN = 24'd1000;
    // shorter windows get clamped up to this
    localparam win_len_t MIN_WIN_LEN     = 24'd4;

    // axi response codes
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

//--- hdl/spike_sync.sv
`timescale 1ns/1ns

module spike_sync (
    input  logic                              reset,
    input  logic                              slow_clk,
    input  logic [spike_pkg::NUM_CHANNELS-1:0] spike,
    output logic [spike_pkg::NUM_CHANNELS-1:0] spike_edge
);

    // first and second synchronizer stages
    logic [spike_pkg::NUM_CHANNELS-1:0] sync_q1;
    logic [spike_pkg::NUM_CHANNELS-1:0] sync_q2;
    // previous synchronized level, for edge detect
    logic [spike_pkg::NUM_CHANNELS-1:0] level_q;

    // two-flop synchronizer, one bit per channel
    always_ff @(posedge reset or posedge slow_clk) begin
        if (slow_clk) begin
            sync_q1 <= '0;
            sync_q2 <= '0;
        end else begin
            sync_q1 <= spike;
            sync_q2 <= sync_q1;
        end
    end

    // remember last level and register the edge pulse
    // so the counters see a clean one-cycle strobe
    always_ff @(posedge reset or posedge slow_clk) begin
        if (slow_clk) begin
            level_q    <= '0;
            spike_edge <= '0;
        end else begin
            level_q    <= sync_q2;
            // rising level only
            spike_edge <= sync_q2 & ~level_q;
        end
    end

    // input edge to pulse is three clocks
    // spike must stay high for two clocks or it may be missed

endmodule

//--- hdl/window_timer.sv
`timescale 1ns/1ns

module window_timer (
    input  logic                reset,
    input  logic                slow_clk,
    input  logic                enable,
    input  spike_pkg::win_len_t win_len,
    output logic                window_end,
    output spike_pkg::win_idx_t win_idx
);

    // position inside the current window
    spike_pkg::win_len_t cyc_cnt;
    // length frozen for the running window
    spike_pkg::win_len_t cur_len;

    // last cycle of the window
    // cur_len never drops below the min, so the subtract is safe
    assign window_end = enable && (cyc_cnt == cur_len - 1'b1);

    always_ff @(posedge reset or posedge slow_clk) begin
        if (slow_clk) begin
            cyc_cnt <= '0;
            cur_len <= spike_pkg::DEFAULT_WIN_LEN;
            win_idx <= '0;
        end else if (!enable) begin
            // idle, hold at window start
            cyc_cnt <= '0;
            // keep tracking the register so the first window uses it
            cur_len <= win_len;
        end else if (window_end) begin
            cyc_cnt <= '0;
            // new length picked up only at a window boundary
            cur_len <= win_len;
            win_idx <= win_idx + 1'b1;
        end else begin
            cyc_cnt <= cyc_cnt + 1'b1;
        end
    end

    // win_idx is free running and wraps after 2^24 windows
    // enable low just parks the cycle counter

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the spike monitor testbench with verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_spike_monitor -f spike_monitor.f -Mdir obj_dir -o tb_spike_monitor
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/tb_spike_monitor > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "=== FAIL ===" "$LOG"; then
    echo "simulation reported failure"
    exit 1
fi
echo "simulation passed"
exit 0

//--- spike_monitor.f
+incdir+verif
hdl/spike_pkg.sv
hdl/spike_sync.sv
hdl/window_timer.sv
hdl/spike_counter.sv
hdl/spike_axil_regs.sv
hdl/spike_monitor_top.sv
verif/tb_spike_monitor.sv

//--- verif/tb_axil_tasks.svh
`ifndef TB_AXIL_TASKS_SVH
`define TB_AXIL_TASKS_SVH

// galois lfsr, x^16 + x^14 + x^13 + x^11 + 1
function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
endfunction

task automatic report_timeout(input string what);
    timeout_cnt++;
    $display("Timeout at %0t: gave up waiting for %s", $time, what);
endtask

// single write, bready held low for hold cycles once bvalid is up
task automatic axil_write(input spike_pkg::axi_addr_t addr, input spike_pkg::axi_data_t data,
                          input int hold, output logic [1:0] resp);
    int waited;
    @(negedge reset);
    awaddr  = addr;
    wdata   = data;
    wstrb   = 4'hF;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    waited  = 0;
    // aw and w are taken in the same cycle
    while (!(awready && wready) && waited < WAIT_LIMIT) begin
        @(negedge reset);
        waited++;
    end
    if (!(awready && wready)) begin
        report_timeout("awready and wready");
    end
    // handshake on the rising edge in between
    @(negedge reset);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    waited  = 0;
    while (!bvalid && waited < WAIT_LIMIT) begin
        @(negedge reset);
        waited++;
    end
    if (!bvalid) begin
        report_timeout("bvalid");
    end
    resp = bresp;
    // response must not move while stalled
    repeat (hold) begin
        @(negedge reset);
        assert (bvalid && bresp == resp) else begin
            err_cnt++;
            $display("Fail at %0t: write response dropped or changed under stall", $time);
        end
    end
    bready = 1'b1;
    @(negedge reset);
    bready = 1'b0;
endtask

// single read, rready held low for hold cycles once rvalid is up
task automatic axil_read(input spike_pkg::axi_addr_t addr, input int hold,
                         output spike_pkg::axi_data_t data, output logic [1:0] resp);
    int waited;
    @(negedge reset);
    araddr  = addr;
    arvalid = 1'b1;
    waited  = 0;
    while (!arready && waited < WAIT_LIMIT) begin
        @(negedge reset);
        waited++;
    end
    if (!arready) begin
        report_timeout("arready");
    end
    @(negedge reset);
    arvalid = 1'b0;
    waited  = 0;
    while (!rvalid && waited < WAIT_LIMIT) begin
        @(negedge reset);
        waited++;
    end
    if (!rvalid) begin
        report_timeout("rvalid");
    end
    data = rdata;
    resp = rresp;
    // data and resp held stable under back-pressure
    repeat (hold) begin
        @(negedge reset);
        assert (rvalid && rdata == data && rresp == resp) else begin
            err_cnt++;
            $display("Fail at %0t: read data dropped or changed under stall", $time);
        end
    end
    rready = 1'b1;
    @(negedge reset);
    rready = 1'b0;
endtask

`endif

//--- verif/tb_spike_monitor.sv
`timescale 1ns/1ns

module tb_spike_monitor;

    // cycles per handshake wait
    localparam int WAIT_LIMIT = 50;
    // register polls before giving up on a window
    localparam int POLL_LIMIT = 500;
    localparam int NCH        = spike_pkg::NUM_CHANNELS;

    // clock and reset of the dut
    logic                 reset = 1'b0;
    logic                 slow_clk;
    logic [NCH-1:0]       spike;
    spike_pkg::axi_addr_t awaddr;
    logic                 awvalid;
    logic                 awready;
    spike_pkg::axi_data_t wdata;
    logic [3:0]           wstrb;
    logic                 wvalid;
    logic                 wready;
    logic [1:0]           bresp;
    logic                 bvalid;
    logic                 bready;
    spike_pkg::axi_addr_t araddr;
    logic                 arvalid;
    logic                 arready;
    spike_pkg::axi_data_t rdata;
    logic [1:0]           rresp;
    logic                 rvalid;
    logic                 rready;

    int                   err_cnt     = 0;
    int                   timeout_cnt = 0;
    logic [15:0]          lfsr_state  = 16'd61205;
    // completed windows counted so far
    spike_pkg::win_idx_t  last_idx;

    // 10 ns period
    always #5 reset = ~reset;

    spike_monitor_top dut (.*);

    `include "tb_axil_tasks.svh"

    task automatic expect_equal(input string what, input logic [31:0] got,
                                input logic [31:0] exp);
        assert (got === exp) else begin
            err_cnt++;
            $display("Fail at %0t: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
        end
    endtask

    // read one register and compare data and response
    task automatic read_check(input spike_pkg::axi_addr_t addr, input logic [31:0] exp,
                              input logic [1:0] exp_resp, input int hold);
        spike_pkg::axi_data_t data;
        logic [1:0]           resp;
        axil_read(addr, hold, data, resp);
        expect_equal($sformatf("rdata at 0x%02h", addr), data, exp);
        expect_equal($sformatf("rresp at 0x%02h", addr), 32'(resp), 32'(exp_resp));
    endtask

    task automatic write_check(input spike_pkg::axi_addr_t addr, input logic [31:0] data,
                               input logic [1:0] exp_resp, input int hold);
        logic [1:0] resp;
        axil_write(addr, data, hold, resp);
        expect_equal($sformatf("bresp at 0x%02h", addr), 32'(resp), 32'(exp_resp));
    endtask

    function automatic spike_pkg::axi_addr_t count_addr(input int ch);
        return spike_pkg::axi_addr_t'(spike_pkg::REG_COUNT_BASE + 4 * ch);
    endfunction

    // one lfsr step per bit taken
    task automatic draw_bits(input int n, output int value);
        value = 0;
        for (int i = 0; i < n; i++) begin
            value      = (value << 1) | lfsr_state[0];
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // poll the window count until it moves past old_idx
    // a poll is far shorter than a window so every step is seen
    task automatic wait_window(input spike_pkg::win_idx_t old_idx,
                               output spike_pkg::win_idx_t new_idx);
        spike_pkg::axi_data_t data;
        logic [1:0]           resp;
        int                   polls;
        spike_pkg::win_idx_t  seen;
        polls   = 0;
        seen    = old_idx;
        new_idx = old_idx + 1'b1;
        while (seen == old_idx && polls < POLL_LIMIT) begin
            axil_read(spike_pkg::REG_WIN_IDX, 0, data, resp);
            seen = data[spike_pkg::WIN_W-1:0];
            polls++;
        end
        if (seen == old_idx) begin
            report_timeout("the window count to advance");
        end else begin
            expect_equal("window count", 32'(seen), 32'(new_idx));
        end
    endtask

    task automatic test_reset_values();
        read_check(spike_pkg::REG_CTRL, 0, spike_pkg::RESP_OKAY, 0);
        read_check(spike_pkg::REG_WIN_LEN, 1000, spike_pkg::RESP_OKAY, 0);
        read_check(spike_pkg::REG_WIN_IDX, 0, spike_pkg::RESP_OKAY, 0);
        for (int ch = 0; ch < NCH; ch++) begin
            read_check(count_addr(ch), 0, spike_pkg::RESP_OKAY, 0);
        end
    endtask

    task automatic test_register_access();
        write_check(spike_pkg::REG_WIN_LEN, 32'h0001_2345, spike_pkg::RESP_OKAY, 0);
        read_check(spike_pkg::REG_WIN_LEN, 32'h0001_2345, spike_pkg::RESP_OKAY, 0);
        // below the floor of 4
        write_check(spike_pkg::REG_WIN_LEN, 2, spike_pkg::RESP_OKAY, 0);
        read_check(spike_pkg::REG_WIN_LEN, 4, spike_pkg::RESP_OKAY, 0);
        write_check(spike_pkg::REG_WIN_IDX, 32'h55, spike_pkg::RESP_SLVERR, 0);
        read_check(spike_pkg::REG_WIN_IDX, 0, spike_pkg::RESP_OKAY, 0);
        // unmapped
        read_check(8'h40, 0, spike_pkg::RESP_SLVERR, 0);
    endtask

    task automatic test_window_counts();
        int                  sent [NCH];
        spike_pkg::win_idx_t idx;
        for (int ch = 0; ch < NCH; ch++) begin
            draw_bits(4, sent[ch]);
            // zero draw becomes one spike
            if (sent[ch] == 0) begin
                sent[ch] = 1;
            end
        end
        write_check(spike_pkg::REG_WIN_LEN, 400, spike_pkg::RESP_OKAY, 0);
        write_check(spike_pkg::REG_CTRL, 1, spike_pkg::RESP_OKAY, 0);
        wait_window(0, idx);
        // all channels in parallel with 3 high and 3 low per spike
        // at most 90 cycles in all
        for (int i = 0; i < 15; i++) begin
            for (int ch = 0; ch < NCH; ch++) begin
                spike[ch] = (i < sent[ch]);
            end
            repeat (3) @(negedge reset);
            spike = '0;
            repeat (3) @(negedge reset);
        end
        wait_window(idx, last_idx);
        for (int ch = 0; ch < NCH; ch++) begin
            read_check(count_addr(ch), sent[ch], spike_pkg::RESP_OKAY, 0);
        end
    endtask

    // a window without spikes latches zero
    task automatic test_empty_window();
        wait_window(last_idx, last_idx);
        for (int ch = 0; ch < NCH; ch++) begin
            read_check(count_addr(ch), 0, spike_pkg::RESP_OKAY, 0);
        end
    endtask

    // disable lands well inside the window after the last poll
    task automatic test_disable();
        write_check(spike_pkg::REG_CTRL, 0, spike_pkg::RESP_OKAY, 0);
        read_check(spike_pkg::REG_WIN_IDX, last_idx, spike_pkg::RESP_OKAY, 0);
        repeat (1000) @(negedge reset);
        read_check(spike_pkg::REG_WIN_IDX, last_idx, spike_pkg::RESP_OKAY, 0);
    endtask

    // 5 stalled cycles on each response channel
    task automatic test_back_pressure();
        write_check(spike_pkg::REG_WIN_LEN, 777, spike_pkg::RESP_OKAY, 5);
        read_check(spike_pkg::REG_WIN_LEN, 777, spike_pkg::RESP_OKAY, 5);
        write_check(8'h0C, 1, spike_pkg::RESP_SLVERR, 5);
        read_check(8'h40, 0, spike_pkg::RESP_SLVERR, 5);
    endtask

    initial begin
        slow_clk = 1'b1;
        spike    = '0;
        awaddr   = '0;
        awvalid  = 1'b0;
        wdata    = '0;
        wstrb    = '0;
        wvalid   = 1'b0;
        bready   = 1'b0;
        araddr   = '0;
        arvalid  = 1'b0;
        rready   = 1'b0;
        last_idx = '0;
        repeat (4) @(posedge reset);
        @(negedge reset);
        slow_clk = 1'b0;
        test_reset_values();
        test_register_access();
        test_window_counts();
        test_empty_window();
        test_disable();
        test_back_pressure();
        $display("failed checks: %0d, timeouts: %0d", err_cnt, timeout_cnt);
        if (err_cnt == 0 && timeout_cnt == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule
